// ==== hw/sched_pkg.sv ====
package sched_pkg;

  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 8;
  localparam int PORT_COUNT = 2;
  localparam int DATA_WIDTH = 64;

  // Slot numbers start at 1, so the width also covers a full count
  localparam int SLOT_WIDTH     = $clog2(SLOT_COUNT + 1);
  localparam int CORE_ID_WIDTH  = $clog2(CORE_COUNT);
  localparam int PORT_ID_WIDTH  = (PORT_COUNT > 1) ? $clog2(PORT_COUNT) : 1;
  localparam int TAG_WIDTH      = 5;
  localparam int DEST_WIDTH     = CORE_ID_WIDTH + TAG_WIDTH;
  localparam int CTRL_WIDTH     = 36;
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int SLOT_LSB       = 16;

  typedef logic [SLOT_WIDTH-1:0]    slot_t;
  typedef logic [CORE_ID_WIDTH-1:0] core_id_t;
  typedef logic [PORT_ID_WIDTH-1:0] port_id_t;
  typedef logic [DEST_WIDTH-1:0]    dest_t;
  typedef logic [CTRL_WIDTH-1:0]    ctrl_word_t;

  typedef enum logic [MSG_TYPE_WIDTH-1:0] {
    SLOT_RETURN = 4'd0,
    SLOT_INIT   = 4'd3
  } msg_type_t;

  typedef enum logic [1:0] {
    STALL = 2'd0,
    FIRST = 2'd1,
    WAIT  = 2'd2,
    MID   = 2'd3
  } port_state_t;

  localparam logic [2:0] REG_INCOME      = 3'd0;
  localparam logic [2:0] REG_ENABLED     = 3'd1;
  localparam logic [2:0] REG_SLOT_COUNT  = 3'd2;
  localparam logic [2:0] REG_FLUSH       = 3'd3;
  localparam logic [2:0] REG_PORT_STATUS = 3'd4;
  localparam logic [2:0] REG_PORT_ENABLE = 3'd5;
  localparam logic [2:0] REG_RELEASE     = 3'd6;

endpackage

// ==== hw/slot_keeper.sv ====
`timescale 1ns/1ps

module slot_keeper #(
  parameter int SLOT_COUNT = sched_pkg::SLOT_COUNT
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             flush,
  input  sched_pkg::slot_t init_count,
  input  logic             init_valid,
  input  sched_pkg::slot_t slot_in,
  input  logic             slot_in_valid,
  input  logic             pop,
  output sched_pkg::slot_t slot_out,
  output logic             slot_out_valid,
  output sched_pkg::slot_t slot_count,
  output logic             enq_err
);

  import sched_pkg::*;

  localparam int PTR_WIDTH = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1;

  slot_t                mem [SLOT_COUNT];
  logic [PTR_WIDTH-1:0] head;
  logic [PTR_WIDTH-1:0] tail;
  slot_t                init_n;
  logic                 full;
  logic                 push;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(SLOT_COUNT - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full           = (slot_count == slot_t'(SLOT_COUNT));
  assign push           = slot_in_valid && !full;
  assign enq_err        = slot_in_valid && full;
  assign slot_out       = mem[head];
  assign slot_out_valid = (slot_count != '0);

  // An init larger than the pool is clipped to the pool size
  assign init_n = (init_count > slot_t'(SLOT_COUNT)) ? slot_t'(SLOT_COUNT) : init_count;

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      head       <= '0;
      tail       <= '0;
      slot_count <= '0;
    end else if (init_valid) begin
      head       <= '0;
      tail       <= (init_n == slot_t'(SLOT_COUNT)) ? '0 : PTR_WIDTH'(init_n);
      slot_count <= init_n;
    end else begin
      if (push)
        tail <= next_ptr(tail);
      if (pop)
        head <= next_ptr(head);
      slot_count <= slot_count + slot_t'(push) - slot_t'(pop);
    end
  end

  // Init lays out slots 1..N from the head
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < SLOT_COUNT; i++)
        mem[i] <= slot_t'(i + 1);
    end else if (push) begin
      mem[tail] <= slot_in;
    end
  end

  // The selector must never hand out a core whose pool is empty
  assert property (@(posedge clk) disable iff (rst_r) pop |-> slot_out_valid)
    else $error("slot_keeper: pop from an empty pool");

endmodule

// ==== hw/core_selector.sv ====
`timescale 1ns/1ps

module core_selector #(
  parameter int CORE_COUNT = sched_pkg::CORE_COUNT
) (
  input  sched_pkg::slot_t [CORE_COUNT-1:0] counts,
  input  logic [CORE_COUNT-1:0]             candidates,
  output sched_pkg::core_id_t               selected,
  output logic                              selected_valid
);

  import sched_pkg::*;

  // Tree is padded to a power of two, node 1 is the root
  localparam int LEAVES = 1 << $clog2(CORE_COUNT);

  slot_t    node_val [1:2*LEAVES-1];
  core_id_t node_idx [1:2*LEAVES-1];

  for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
    if (i < CORE_COUNT) begin : g_core
      // Non-candidates enter with zero so they never win
      assign node_val[LEAVES+i] = candidates[i] ? counts[i] : '0;
    end else begin : g_pad
      assign node_val[LEAVES+i] = '0;
    end
    assign node_idx[LEAVES+i] = core_id_t'(i);
  end

  for (genvar n = LEAVES - 1; n >= 1; n--) begin : g_node
    logic take_right;

    // Ties stay on the left, lower core index
    assign take_right  = node_val[2*n+1] > node_val[2*n];
    assign node_val[n] = take_right ? node_val[2*n+1] : node_val[2*n];
    assign node_idx[n] = take_right ? node_idx[2*n+1] : node_idx[2*n];
  end

  assign selected       = node_idx[1];
  assign selected_valid = (node_val[1] != '0);

endmodule

// ==== hw/port_dispatch.sv ====
`timescale 1ns/1ps

module port_dispatch #(
  parameter int PORT_COUNT = sched_pkg::PORT_COUNT
) (
  input  logic                                    clk,
  input  logic                                    rst_r,
  input  logic [PORT_COUNT-1:0]                   rx_tvalid,
  input  logic [PORT_COUNT-1:0]                   rx_tlast,
  input  logic [PORT_COUNT-1:0]                   out_tready,
  input  logic [PORT_COUNT-1:0]                   enabled_ports,
  input  logic [PORT_COUNT-1:0]                   release_desc,
  input  sched_pkg::core_id_t                     desc_core,
  input  sched_pkg::slot_t                        desc_slot,
  input  logic                                    desc_valid,
  output logic [PORT_COUNT-1:0]                   rx_tready,
  output logic [PORT_COUNT-1:0]                   out_tvalid,
  output sched_pkg::dest_t [PORT_COUNT-1:0]       out_tdest,
  output logic                                    desc_pop,
  output sched_pkg::port_state_t [PORT_COUNT-1:0] port_state,
  output sched_pkg::dest_t [PORT_COUNT-1:0]       next_dest
);

  import sched_pkg::*;

  logic [PORT_COUNT-1:0]        not_stall;
  logic [PORT_COUNT-1:0]        moving;
  logic [PORT_COUNT-1:0]        last_word;
  logic [PORT_COUNT-1:0]        desc_req;
  logic [PORT_COUNT-1:0]        grant;
  port_id_t                     grant_idx;
  port_id_t                     rr_ptr;
  port_state_t [PORT_COUNT-1:0] state_next;
  dest_t [PORT_COUNT-1:0]       cur_dest;
  dest_t                        desc_dest;

  assign desc_dest = {desc_core, TAG_WIDTH'(desc_slot)};
  assign desc_pop  = |grant;

  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
    assign not_stall[p]  = (port_state[p] != STALL) && enabled_ports[p];
    assign rx_tready[p]  = out_tready[p] && not_stall[p];
    assign out_tvalid[p] = rx_tvalid[p] && not_stall[p];
    assign moving[p]     = rx_tvalid[p] && rx_tready[p];
    assign last_word[p]  = moving[p] && rx_tlast[p];
    // Disabled ports reserve no descriptor
    assign desc_req[p]   = enabled_ports[p] &&
                           ((port_state[p] == STALL) || (port_state[p] == WAIT) ||
                            ((port_state[p] == FIRST) && moving[p]));
    // In FIRST the packet starts on the freshly reserved descriptor
    assign out_tdest[p]  = (port_state[p] == FIRST) ? next_dest[p] : cur_dest[p];
  end

  // A popped descriptor always names a real slot of the selected pool
  assert property (@(posedge clk) disable iff (rst_r)
    desc_pop |-> desc_valid && (desc_slot != '0))
    else $error("port_dispatch: descriptor popped without a valid slot");

  // Round-robin search starting at rr_ptr
  always_comb begin
    int unsigned idx;
    logic        found;
    grant     = '0;
    grant_idx = '0;
    found     = 1'b0;
    for (int k = 0; k < PORT_COUNT; k++) begin
      idx = (int'(rr_ptr) + k) % PORT_COUNT;
      if (desc_valid && desc_req[idx] && !found) begin
        grant[idx] = 1'b1;
        grant_idx  = port_id_t'(idx);
        found      = 1'b1;
      end
    end
  end

  always_comb begin
    for (int p = 0; p < PORT_COUNT; p++) begin
      state_next[p] = port_state[p];
      case (port_state[p])
        STALL: begin
          if (grant[p])
            state_next[p] = FIRST;
        end
        FIRST: begin
          // Grant in the same cycle replaces the descriptor just used
          if (last_word[p])
            state_next[p] = grant[p] ? FIRST : STALL;
          else if (moving[p])
            state_next[p] = grant[p] ? MID : WAIT;
          else if (release_desc[p])
            state_next[p] = STALL;
        end
        WAIT: begin
          if (grant[p] && last_word[p])
            state_next[p] = FIRST;
          else if (grant[p])
            state_next[p] = MID;
          else if (last_word[p])
            state_next[p] = STALL;
        end
        MID: begin
          if (last_word[p])
            state_next[p] = release_desc[p] ? STALL : FIRST;
          else if (release_desc[p])
            state_next[p] = WAIT;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rr_ptr <= '0;
      for (int p = 0; p < PORT_COUNT; p++) begin
        port_state[p] <= STALL;
        next_dest[p]  <= '0;
      end
    end else begin
      if (desc_pop)
        rr_ptr <= (grant_idx == port_id_t'(PORT_COUNT - 1)) ? '0 : grant_idx + 1'b1;
      for (int p = 0; p < PORT_COUNT; p++) begin
        port_state[p] <= state_next[p];
        if ((port_state[p] == FIRST) && moving[p])
          cur_dest[p] <= next_dest[p];
        if (grant[p])
          next_dest[p] <= desc_dest;
      end
    end
  end

endmodule

// ==== hw/host_regs.sv ====
`timescale 1ns/1ps

module host_regs #(
  parameter int CORE_COUNT = sched_pkg::CORE_COUNT,
  parameter int PORT_COUNT = sched_pkg::PORT_COUNT
) (
  input  logic                                    clk,
  input  logic                                    rst_r,
  input  logic [31:0]                             host_cmd,
  input  logic [31:0]                             host_wr_data,
  input  logic                                    host_cmd_valid,
  input  sched_pkg::slot_t [CORE_COUNT-1:0]       slot_counts,
  input  sched_pkg::port_state_t [PORT_COUNT-1:0] port_state,
  input  sched_pkg::dest_t [PORT_COUNT-1:0]       next_dest,
  output logic [31:0]                             host_rd_data,
  output logic [CORE_COUNT-1:0]                   income_cores,
  output logic [CORE_COUNT-1:0]                   flush,
  output logic [PORT_COUNT-1:0]                   enabled_ports,
  output logic [PORT_COUNT-1:0]                   release_desc
);

  import sched_pkg::*;

  logic                  wr_valid_r;
  logic [2:0]            addr_r;
  logic [31:0]           wr_data_r;
  core_id_t              core_sel_r;
  port_id_t              port_sel_r;
  logic [CORE_COUNT-1:0] enabled_cores;
  logic [31:0]           rd_data_n;
  dest_t                 status_dest;

  always_ff @(posedge clk) begin
    wr_data_r <= host_wr_data;
    if (rst_r) begin
      wr_valid_r <= 1'b0;
      addr_r     <= '0;
      core_sel_r <= '0;
      port_sel_r <= '0;
    end else begin
      wr_valid_r <= host_cmd_valid && host_cmd[31];
      // Readback follows the last command, read or write
      if (host_cmd_valid) begin
        addr_r     <= host_cmd[29:27];
        core_sel_r <= host_cmd[CORE_ID_WIDTH-1:0];
        port_sel_r <= host_cmd[PORT_ID_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      income_cores  <= '0;
      enabled_cores <= '0;
      enabled_ports <= '0;
      flush         <= '0;
      release_desc  <= '0;
    end else begin
      flush        <= '0;
      release_desc <= '0;
      if (wr_valid_r) begin
        case (addr_r)
          // A core that is not enabled can never take traffic
          REG_INCOME:
            income_cores <= wr_data_r[CORE_COUNT-1:0] & enabled_cores;
          REG_ENABLED: begin
            enabled_cores <= wr_data_r[CORE_COUNT-1:0];
            income_cores  <= income_cores & wr_data_r[CORE_COUNT-1:0];
          end
          REG_FLUSH:       flush         <= wr_data_r[CORE_COUNT-1:0];
          REG_PORT_ENABLE: enabled_ports <= wr_data_r[PORT_COUNT-1:0];
          REG_RELEASE:     release_desc  <= wr_data_r[PORT_COUNT-1:0];
          default: ;
        endcase
      end
    end
  end

  assign status_dest = next_dest[port_sel_r];

  always_comb begin
    case (addr_r)
      REG_INCOME:      rd_data_n = 32'(income_cores);
      REG_ENABLED:     rd_data_n = 32'(enabled_cores);
      REG_SLOT_COUNT:  rd_data_n = 32'(slot_counts[core_sel_r]);
      REG_PORT_STATUS: rd_data_n = {14'd0, port_state[port_sel_r],
                                    8'(status_dest[DEST_WIDTH-1 -: CORE_ID_WIDTH]),
                                    3'd0, status_dest[TAG_WIDTH-1:0]};
      REG_PORT_ENABLE: rd_data_n = 32'(enabled_ports);
      default:         rd_data_n = 32'hFEFE_FEFE;
    endcase
  end

  always_ff @(posedge clk)
    host_rd_data <= rd_data_n;

endmodule

// ==== hw/rx_scheduler.sv ====
`timescale 1ns/1ps

module rx_scheduler #(
  parameter int CORE_COUNT = sched_pkg::CORE_COUNT,
  parameter int SLOT_COUNT = sched_pkg::SLOT_COUNT,
  parameter int PORT_COUNT = sched_pkg::PORT_COUNT,
  parameter int DATA_WIDTH = sched_pkg::DATA_WIDTH
) (
  input  logic                                    clk,
  input  logic                                    rst_r,
  input  logic [PORT_COUNT-1:0][DATA_WIDTH-1:0]   rx_tdata,
  input  logic [PORT_COUNT-1:0][DATA_WIDTH/8-1:0] rx_tkeep,
  input  logic [PORT_COUNT-1:0]                   rx_tvalid,
  output logic [PORT_COUNT-1:0]                   rx_tready,
  input  logic [PORT_COUNT-1:0]                   rx_tlast,
  output logic [PORT_COUNT-1:0][DATA_WIDTH-1:0]   out_tdata,
  output logic [PORT_COUNT-1:0][DATA_WIDTH/8-1:0] out_tkeep,
  output logic [PORT_COUNT-1:0]                   out_tvalid,
  input  logic [PORT_COUNT-1:0]                   out_tready,
  output logic [PORT_COUNT-1:0]                   out_tlast,
  output sched_pkg::dest_t [PORT_COUNT-1:0]       out_tdest,
  output sched_pkg::port_id_t [PORT_COUNT-1:0]    out_tuser,
  input  logic                                    ctrl_valid,
  input  sched_pkg::ctrl_word_t                   ctrl_data,
  input  sched_pkg::core_id_t                     ctrl_core,
  input  logic [31:0]                             host_cmd,
  input  logic [31:0]                             host_wr_data,
  input  logic                                    host_cmd_valid,
  output logic [31:0]                             host_rd_data,
  output logic                                    slot_err
);

  import sched_pkg::*;

  msg_type_t                    msg_type;
  logic [CORE_COUNT-1:0]        init_v;
  logic [CORE_COUNT-1:0]        ret_v;
  slot_t                        slot_r;
  logic [CORE_COUNT-1:0]        income_cores;
  logic [CORE_COUNT-1:0]        flush;
  logic [CORE_COUNT-1:0]        enq_err;
  logic [CORE_COUNT-1:0]        head_valid;
  logic [CORE_COUNT-1:0]        pop;
  slot_t [CORE_COUNT-1:0]       head_slot;
  slot_t [CORE_COUNT-1:0]       slot_counts;
  logic [PORT_COUNT-1:0]        enabled_ports;
  logic [PORT_COUNT-1:0]        release_desc;
  core_id_t                     sel_core;
  logic                         sel_valid;
  logic                         desc_pop;
  port_state_t [PORT_COUNT-1:0] port_state;
  dest_t [PORT_COUNT-1:0]       next_dest;

  assign msg_type = msg_type_t'(ctrl_data[CTRL_WIDTH-1 -: MSG_TYPE_WIDTH]);

  // Message strobes land in the pools one cycle after this stage
  always_ff @(posedge clk) begin
    slot_r <= ctrl_data[SLOT_LSB +: SLOT_WIDTH];
    if (rst_r) begin
      init_v   <= '0;
      ret_v    <= '0;
      slot_err <= 1'b0;
    end else begin
      for (int i = 0; i < CORE_COUNT; i++) begin
        init_v[i] <= ctrl_valid && (msg_type == SLOT_INIT) && (ctrl_core == core_id_t'(i));
        ret_v[i]  <= ctrl_valid && (msg_type == SLOT_RETURN) && (ctrl_core == core_id_t'(i));
      end
      slot_err <= |enq_err;
    end
  end

  host_regs #(
    .CORE_COUNT(CORE_COUNT),
    .PORT_COUNT(PORT_COUNT)
  ) u_host_regs (
    .clk           (clk),
    .rst_r         (rst_r),
    .host_cmd      (host_cmd),
    .host_wr_data  (host_wr_data),
    .host_cmd_valid(host_cmd_valid),
    .slot_counts   (slot_counts),
    .port_state    (port_state),
    .next_dest     (next_dest),
    .host_rd_data  (host_rd_data),
    .income_cores  (income_cores),
    .flush         (flush),
    .enabled_ports (enabled_ports),
    .release_desc  (release_desc)
  );

  for (genvar i = 0; i < CORE_COUNT; i++) begin : g_core
    assign pop[i] = desc_pop && (sel_core == core_id_t'(i));

    slot_keeper #(
      .SLOT_COUNT(SLOT_COUNT)
    ) u_slot_keeper (
      .clk           (clk),
      .rst_r         (rst_r),
      .flush         (flush[i]),
      .init_count    (slot_r),
      .init_valid    (init_v[i]),
      .slot_in       (slot_r),
      .slot_in_valid (ret_v[i]),
      .pop           (pop[i]),
      .slot_out      (head_slot[i]),
      .slot_out_valid(head_valid[i]),
      .slot_count    (slot_counts[i]),
      .enq_err       (enq_err[i])
    );
  end

  core_selector #(
    .CORE_COUNT(CORE_COUNT)
  ) u_core_selector (
    .counts        (slot_counts),
    .candidates    (income_cores),
    .selected      (sel_core),
    .selected_valid(sel_valid)
  );

  port_dispatch #(
    .PORT_COUNT(PORT_COUNT)
  ) u_port_dispatch (
    .clk          (clk),
    .rst_r        (rst_r),
    .rx_tvalid    (rx_tvalid),
    .rx_tlast     (rx_tlast),
    .out_tready   (out_tready),
    .enabled_ports(enabled_ports),
    .release_desc (release_desc),
    .desc_core    (sel_core),
    .desc_slot    (head_slot[sel_core]),
    .desc_valid   (sel_valid && head_valid[sel_core]),
    .rx_tready    (rx_tready),
    .out_tvalid   (out_tvalid),
    .out_tdest    (out_tdest),
    .desc_pop     (desc_pop),
    .port_state   (port_state),
    .next_dest    (next_dest)
  );

  // Payload passes straight through, only valid and ready are gated
  assign out_tdata = rx_tdata;
  assign out_tkeep = rx_tkeep;
  assign out_tlast = rx_tlast;

  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_user
    assign out_tuser[p] = port_id_t'(p);
  end

endmodule

// ==== dv/tb_rx_scheduler.sv ====
`timescale 1ns/1ps

module tb_rx_scheduler;

  import sched_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int KEEP_WIDTH   = DATA_WIDTH / 8;
  localparam int WORD_TIMEOUT = 40;
  // Cycle budget for reset and then each test in run order
  localparam int TEST_CYCLES  = 10 + 60 + 80 + 150 + 120 + 120;
  localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_PERIOD;

  logic                                  clk;
  logic                                  rst_r;
  logic [PORT_COUNT-1:0][DATA_WIDTH-1:0] rx_tdata;
  logic [PORT_COUNT-1:0][DATA_WIDTH-1:0] out_tdata;
  logic [PORT_COUNT-1:0][KEEP_WIDTH-1:0] rx_tkeep;
  logic [PORT_COUNT-1:0][KEEP_WIDTH-1:0] out_tkeep;
  logic [PORT_COUNT-1:0]                 rx_tvalid;
  logic [PORT_COUNT-1:0]                 rx_tready;
  logic [PORT_COUNT-1:0]                 rx_tlast;
  logic [PORT_COUNT-1:0]                 out_tvalid;
  logic [PORT_COUNT-1:0]                 out_tready;
  logic [PORT_COUNT-1:0]                 out_tlast;
  dest_t [PORT_COUNT-1:0]                out_tdest;
  port_id_t [PORT_COUNT-1:0]             out_tuser;
  logic                                  ctrl_valid;
  ctrl_word_t                            ctrl_data;
  core_id_t                              ctrl_core;
  logic [31:0]                           host_cmd;
  logic [31:0]                           host_wr_data;
  logic                                  host_cmd_valid;
  logic [31:0]                           host_rd_data;
  logic                                  slot_err;

  string cur_test;
  int    error_count;
  int    test_count;
  int    failed_tests;
  int    test_start_errors;

  rx_scheduler #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT),
    .PORT_COUNT(PORT_COUNT),
    .DATA_WIDTH(DATA_WIDTH)
  ) UUT (
    .clk           (clk),
    .rst_r         (rst_r),
    .rx_tdata      (rx_tdata),
    .rx_tkeep      (rx_tkeep),
    .rx_tvalid     (rx_tvalid),
    .rx_tready     (rx_tready),
    .rx_tlast      (rx_tlast),
    .out_tdata     (out_tdata),
    .out_tkeep     (out_tkeep),
    .out_tvalid    (out_tvalid),
    .out_tready    (out_tready),
    .out_tlast     (out_tlast),
    .out_tdest     (out_tdest),
    .out_tuser     (out_tuser),
    .ctrl_valid    (ctrl_valid),
    .ctrl_data     (ctrl_data),
    .ctrl_core     (ctrl_core),
    .host_cmd      (host_cmd),
    .host_wr_data  (host_wr_data),
    .host_cmd_valid(host_cmd_valid),
    .host_rd_data  (host_rd_data),
    .slot_err      (slot_err)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    $display("STATUS: FAIL");
    $finish;
  end

  // Destination is the core index above a 5-bit slot tag
  function automatic dest_t make_dest(input int core, input int slot);
    return dest_t'((core << TAG_WIDTH) | slot);
  endfunction

  function automatic logic [31:0] build_cmd(input logic wr, input logic [2:0] addr,
                                            input int sel);
    logic [31:0] cmd;
    cmd        = '0;
    cmd[31]    = wr;
    cmd[29:27] = addr;
    cmd[7:0]   = 8'(sel);
    return cmd;
  endfunction

  task automatic compare_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Error %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test          = name;
    test_start_errors = error_count;
    test_count++;
  endtask

  task automatic end_test();
    if (error_count == test_start_errors) begin
      $display("%s: passed", cur_test);
    end else begin
      $display("%s: failed with %0d errors", cur_test, error_count - test_start_errors);
      failed_tests++;
    end
  endtask

  task automatic host_write(input logic [2:0] addr, input logic [31:0] data);
    @(posedge clk);
    host_cmd       <= build_cmd(1'b1, addr, 0);
    host_wr_data   <= data;
    host_cmd_valid <= 1'b1;
    @(posedge clk);
    host_cmd_valid <= 1'b0;
  endtask

  // Readback is valid two cycles after the command is taken
  task automatic host_read(input logic [2:0] addr, input int sel, output logic [31:0] data);
    @(posedge clk);
    host_cmd       <= build_cmd(1'b0, addr, sel);
    host_cmd_valid <= 1'b1;
    @(posedge clk);
    host_cmd_valid <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    data = host_rd_data;
  endtask

  task automatic send_ctrl(input msg_type_t mtype, input int core, input int slot);
    ctrl_word_t word;
    word                           = '0;
    word[CTRL_WIDTH-1 -: 4]        = mtype;
    word[SLOT_LSB +: SLOT_WIDTH]   = slot_t'(slot);
    @(posedge clk);
    ctrl_data  <= word;
    ctrl_core  <= core_id_t'(core);
    ctrl_valid <= 1'b1;
    @(posedge clk);
    ctrl_valid <= 1'b0;
  endtask

  task automatic watch_slot_err(output bit seen);
    seen = 1'b0;
    repeat (4) begin
      @(negedge clk);
      if (slot_err)
        seen = 1'b1;
    end
  endtask

  task automatic send_packet(input int port, input int words, input int core,
                             input int slot);
    logic [DATA_WIDTH-1:0] data;
    logic [KEEP_WIDTH-1:0] keep;
    int                    waited;
    for (int w = 0; w < words; w++) begin
      data = {$urandom, $urandom};
      keep = KEEP_WIDTH'($urandom);
      @(posedge clk);
      rx_tvalid[port] <= 1'b1;
      rx_tdata[port]  <= data;
      rx_tkeep[port]  <= keep;
      rx_tlast[port]  <= (w == words - 1);
      waited = 0;
      @(negedge clk);
      while (!(out_tvalid[port] && rx_tready[port]) && waited < WORD_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (waited >= WORD_TIMEOUT) begin
        $display("%s: port %0d never passed word %0d to the output", cur_test, port, w);
        error_count++;
      end else begin
        compare_value("tdata", data, out_tdata[port]);
        compare_value("tkeep", keep, out_tkeep[port]);
        compare_value("tlast", (w == words - 1), out_tlast[port]);
        compare_value("tdest", make_dest(core, slot), out_tdest[port]);
        compare_value("tuser", port, out_tuser[port]);
      end
    end
    @(posedge clk);
    rx_tvalid[port] <= 1'b0;
    rx_tlast[port]  <= 1'b0;
  endtask

  task automatic check_stalled(input int port, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      compare_value("rx_tready", 0, rx_tready[port]);
      compare_value("out_tvalid", 0, out_tvalid[port]);
    end
  endtask

  // Returns the port to STALL and empties every pool
  task automatic clear_ports_and_pools(input logic [PORT_COUNT-1:0] held);
    host_write(REG_PORT_ENABLE, 32'h0);
    host_write(REG_RELEASE, 32'(held));
    host_write(REG_FLUSH, 32'hF);
  endtask

  task automatic register_readback();
    logic [31:0] rd;
    begin_test("register_access");
    host_write(REG_ENABLED, 32'h5);
    host_read(REG_ENABLED, 0, rd);
    compare_value("enabled mask", 32'h5, rd);
    host_write(REG_INCOME, 32'hF);
    host_read(REG_INCOME, 0, rd);
    compare_value("incoming mask", 32'h5, rd);
    host_write(REG_PORT_ENABLE, 32'h3);
    host_read(REG_PORT_ENABLE, 0, rd);
    compare_value("port enables", 32'h3, rd);
    host_read(3'd7, 0, rd);
    compare_value("unmapped address", 32'hFEFE_FEFE, rd);
    host_write(REG_PORT_ENABLE, 32'h0);
    end_test();
  endtask

  task automatic slot_pool_counts();
    logic [31:0] rd;
    bit          seen;
    begin_test("slot_pools");
    host_write(REG_ENABLED, 32'hF);
    host_write(REG_INCOME, 32'h0);
    send_ctrl(SLOT_INIT, 1, 5);
    host_read(REG_SLOT_COUNT, 1, rd);
    compare_value("count after init", 5, rd);
    send_ctrl(SLOT_RETURN, 1, 7);
    watch_slot_err(seen);
    compare_value("slot_err on partial pool", 0, seen);
    host_read(REG_SLOT_COUNT, 1, rd);
    compare_value("count after return", 6, rd);
    send_ctrl(SLOT_INIT, 2, SLOT_COUNT);
    send_ctrl(SLOT_RETURN, 2, 3);
    watch_slot_err(seen);
    compare_value("slot_err on full pool", 1, seen);
    host_read(REG_SLOT_COUNT, 2, rd);
    compare_value("count of full pool", SLOT_COUNT, rd);
    host_write(REG_FLUSH, 32'hF);
    end_test();
  endtask

  task automatic descriptor_stamping();
    begin_test("stamping");
    host_write(REG_INCOME, 32'b0100);
    send_ctrl(SLOT_INIT, 2, 4);
    host_write(REG_PORT_ENABLE, 32'b10);
    send_packet(1, 2, 2, 1);
    send_packet(1, 1, 2, 2);
    send_packet(1, 3, 2, 3);
    clear_ports_and_pools(2'b10);
    end_test();
  endtask

  task automatic core_selection();
    logic [31:0] rd;
    begin_test("core_selection");
    send_ctrl(SLOT_INIT, 0, 3);
    send_ctrl(SLOT_INIT, 3, 6);
    host_write(REG_INCOME, 32'b1001);
    host_write(REG_PORT_ENABLE, 32'b01);
    host_read(REG_PORT_STATUS, 0, rd);
    compare_value("larger pool wins", (32'(FIRST) << 16) | (3 << 8) | 1, rd);
    clear_ports_and_pools(2'b01);
    send_ctrl(SLOT_INIT, 1, 4);
    send_ctrl(SLOT_INIT, 2, 4);
    host_write(REG_INCOME, 32'b0110);
    host_write(REG_PORT_ENABLE, 32'b01);
    host_read(REG_PORT_STATUS, 0, rd);
    compare_value("tie goes to lower core", (32'(FIRST) << 16) | (1 << 8) | 1, rd);
    clear_ports_and_pools(2'b01);
    end_test();
  endtask

  task automatic stall_conditions();
    logic [31:0] rd;
    begin_test("stall_cases");
    send_ctrl(SLOT_INIT, 0, 2);
    host_write(REG_INCOME, 32'b0001);
    @(posedge clk);
    rx_tvalid[1] <= 1'b1;
    rx_tdata[1]  <= {$urandom, $urandom};
    // Port 1 still disabled while core 0 has slots
    check_stalled(1, 8);
    host_read(REG_PORT_STATUS, 1, rd);
    compare_value("state while disabled", 32'(STALL), rd[17:16]);
    host_write(REG_INCOME, 32'h0);
    host_write(REG_PORT_ENABLE, 32'b10);
    check_stalled(1, 8);
    host_read(REG_PORT_STATUS, 1, rd);
    compare_value("state with no incoming core", 32'(STALL), rd[17:16]);
    host_write(REG_FLUSH, 32'b0001);
    host_write(REG_INCOME, 32'b0001);
    host_read(REG_SLOT_COUNT, 0, rd);
    compare_value("count after flush", 0, rd);
    check_stalled(1, 8);
    host_read(REG_PORT_STATUS, 1, rd);
    compare_value("state after flush", 32'(STALL), rd[17:16]);
    @(posedge clk);
    rx_tvalid[1] <= 1'b0;
    host_write(REG_PORT_ENABLE, 32'h0);
    end_test();
  endtask

  initial begin
    void'($urandom(40));
    error_count    = 0;
    test_count     = 0;
    failed_tests   = 0;
    rst_r          = 1'b1;
    rx_tdata       = '0;
    rx_tkeep       = '0;
    rx_tvalid      = '0;
    rx_tlast       = '0;
    out_tready     = '1;
    ctrl_valid     = 1'b0;
    ctrl_data      = '0;
    ctrl_core      = '0;
    host_cmd       = '0;
    host_wr_data   = '0;
    host_cmd_valid = 1'b0;
    repeat (10) @(posedge clk);
    rst_r <= 1'b0;

    register_readback();
    slot_pool_counts();
    descriptor_stamping();
    core_selection();
    stall_conditions();

    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
hw/sched_pkg.sv
hw/slot_keeper.sv
hw/core_selector.sv
hw/port_dispatch.sv
hw/host_regs.sv
hw/rx_scheduler.sv
dv/tb_rx_scheduler.sv
